// ==== cache_geom_pkg.sv ====
// ====================
// Cache geometry types
// ====================

package cache_geom_pkg;

  // Address split of a 32-bit byte address
  localparam int unsigned tag_bits       = 22;
  localparam int unsigned index_bits     = 6;
  localparam int unsigned word_bits      = 32;
  localparam int unsigned words_per_line = 4;
  localparam int unsigned num_lines      = 2 ** index_bits;
  localparam int unsigned line_bits      = words_per_line * word_bits;

  typedef logic [tag_bits-1:0]                tag_t;
  typedef logic [index_bits-1:0]              index_t;
  typedef logic [$clog2(words_per_line)-1:0]  offset_t;
  typedef logic [word_bits-1:0]               word_t;

  // Fetch address, MSB first
  typedef struct packed {
    tag_t       tag;
    index_t     index;
    offset_t    word;
    logic [1:0] byte_sel;
  } fetch_addr_t;

  // One cache line, seen as raw bits or as four words
  typedef union packed {
    logic [line_bits-1:0]            raw;
    word_t [words_per_line-1:0]      words;
  } line_u;

endpackage

// ==== fetch_bus_pkg.sv ====
// ====================
// Fetch and refill bus types
// ====================

package fetch_bus_pkg;

  import cache_geom_pkg::*;

  // Core fetch port, held until completion
  typedef struct packed {
    logic        req;
    fetch_addr_t addr;
  } fetch_req_t;

  // Memory refill response
  // stall is the memory wait level, high while no word is offered
  typedef struct packed {
    word_t data;
    logic  stall;
  } mem_rsp_t;

  // ====================
  // Statistics
  // ====================

  typedef struct packed {
    logic [31:0] fetches;
    logic [31:0] hits;
    logic [31:0] misses;
  } cache_stats_t;

endpackage

// ==== tag_store.sv ====
// ====================
// Tag and valid array
// ====================

`timescale 1ns/10ps

module tag_store
  import cache_geom_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  index_t index,
  input  tag_t   tag,
  input  logic   rd,
  input  logic   wr,
  output logic   hit,
  output logic   line_valid
);

  tag_t                 tags [num_lines];
  logic [num_lines-1:0] valid;
  tag_t                 rd_tag;
  logic                 rd_valid;

  always_ff @(posedge clk) begin
    if (wr) tags[index] <= tag;
  end

  // Valid bits per line
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= '0;
    end else if (wr) begin
      valid[index] <= 1'b1;
    end
  end

  // Synchronous read port
  always_ff @(posedge clk) begin
    if (rd) rd_tag <= tags[index];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else if (rd) begin
      rd_valid <= valid[index];
    end
  end

  // Compare against the held tag one cycle after the read
  assign hit        = rd_valid & (rd_tag == tag);
  assign line_valid = valid[index];

endmodule

// ==== line_store.sv ====
// ====================
// Line data array
// ====================

`timescale 1ns/10ps

module line_store
  import cache_geom_pkg::*;
(
  input  logic                      clk,
  input  index_t                    index,
  input  logic                      rd,
  input  logic [words_per_line-1:0] wr,
  input  line_u                     wdata,
  output line_u                     rdata
);

  logic [line_bits-1:0] lines [num_lines];

  // Word-granular write
  always_ff @(posedge clk) begin
    for (int w = 0; w < words_per_line; w++) begin
      if (wr[w]) begin
        lines[index][w*word_bits +: word_bits] <= wdata.raw[w*word_bits +: word_bits];
      end
    end
  end

  // Registered read, held until the next read strobe
  always_ff @(posedge clk) begin
    if (rd) rdata.raw <= lines[index];
  end

  // ====================
  // Checks
  // ====================

  // One shared index, so a read and a write would collide on the same line
  a_no_rd_wr_collide: assert property (
    @(posedge clk) !(rd && (|wr))
  ) else $error("line_store: read and write of index %0d in one cycle", index);

endmodule

// ==== fetch_decode.sv ====
// ====================
// Fetch address decode
// ====================

`timescale 1ns/10ps

module fetch_decode
  import cache_geom_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fetch_req_t  fetch,
  input  logic        capture,
  output fetch_addr_t held_addr,
  output index_t      index,
  output tag_t        tag,
  output offset_t     word
);

  fetch_addr_t live_addr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      held_addr <= '0;
    end else if (capture) begin
      held_addr <= fetch.addr;
    end
  end

  // Request cycle uses the core address directly so the stores read at once
  assign live_addr = capture ? fetch.addr : held_addr;

  assign index = live_addr.index;
  assign tag   = live_addr.tag;
  assign word  = live_addr.word;

endmodule

// ==== icache_ctrl.sv ====
// ====================
// Instruction cache FSM
// ====================

`timescale 1ns/10ps

module icache_ctrl
  import cache_geom_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  fetch_req_t                fetch,
  input  mem_rsp_t                  mem,
  input  logic                      valid_hit,
  input  logic                      line_valid,
  output logic                      idle,
  output logic                      capture,
  output logic                      tag_wr,
  output logic [words_per_line-1:0] line_wr,
  output offset_t                   beat,
  output logic                      refill_done,
  output logic                      hit_done,
  output logic                      core_wait,
  output logic                      mem_req
);

  typedef enum logic [1:0] {
    s_idle,
    s_check,
    s_refill,
    s_finish
  } state_t;

  state_t      state;
  state_t      state_nxt;
  logic [2:0]  beat_cnt;
  logic        line_full;
  logic        beat_ok;

  // ====================
  // State register
  // ====================

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= s_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      s_idle: begin
        // An invalid line cannot hit so the compare is skipped
        if (fetch.req) state_nxt = line_valid ? s_check : s_refill;
      end
      s_check:  state_nxt = valid_hit ? s_finish : s_refill;
      s_refill: begin
        if (line_full) state_nxt = s_finish;
      end
      s_finish: state_nxt = s_idle;
      default:  state_nxt = s_idle;
    endcase
  end

  // ====================
  // Refill beat counter
  // ====================

  assign line_full = beat_cnt[2];
  assign beat_ok   = (state == s_refill) & ~line_full & ~mem.stall;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (state != s_refill) begin
      beat_cnt <= '0;
    end else if (beat_ok) begin
      beat_cnt <= beat_cnt + 3'd1;
    end
  end

  assign beat = beat_cnt[1:0];

  // Strobes to decode, stores and result
  assign idle        = (state == s_idle);
  assign capture     = idle & fetch.req;
  assign hit_done    = (state == s_check) & valid_hit;
  assign refill_done = (state == s_refill) & line_full;

  // Tag goes in with the first beat and data once the whole line is buffered
  assign tag_wr  = beat_ok & (beat_cnt == 3'd0);
  assign line_wr = {words_per_line{refill_done}};

  // Port-side handshakes
  assign mem_req   = (state == s_refill) & ~line_full;
  assign core_wait = idle ? fetch.req : (state != s_finish);

endmodule

// ==== fetch_result.sv ====
// ====================
// Refill buffer and result
// ====================

`timescale 1ns/10ps

module fetch_result
  import cache_geom_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  mem_rsp_t     mem,
  input  offset_t      beat,
  input  logic         refill_done,
  input  logic         hit_done,
  input  logic         idle,
  input  fetch_req_t   fetch,
  input  offset_t      word,
  input  line_u        store_line,
  output line_u        fill_line,
  output word_t        core_data,
  output cache_stats_t stats
);

  logic beat_take;

  // Refill buffer filled by beat number
  assign beat_take = ~mem.stall & ~idle & ~refill_done;

  always_ff @(posedge clk) begin
    if (beat_take) fill_line.words[beat] <= mem.data;
  end

  // Output word register
  always_ff @(posedge clk) begin
    if (hit_done) begin
      core_data <= store_line.words[word];
    end else if (refill_done) begin
      core_data <= fill_line.words[word];
    end
  end

  // ====================
  // Statistics
  // ====================

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stats <= '0;
    end else begin
      if (idle && fetch.req) stats.fetches <= stats.fetches + 32'd1;
      if (hit_done) stats.hits <= stats.hits + 32'd1;
      // One miss per completed refill
      if (refill_done) stats.misses <= stats.misses + 32'd1;
    end
  end

endmodule

// ==== icache_top.sv ====
// ====================
// L1 instruction cache
// ====================

`timescale 1ns/10ps

module icache_top
  import cache_geom_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  fetch_req_t   fetch,
  output word_t        core_data,
  output logic         core_wait,
  output logic         mem_req,
  output word_t        mem_addr,
  input  mem_rsp_t     mem,
  output cache_stats_t stats
);

  fetch_addr_t               held_addr;
  index_t                    index;
  tag_t                      tag;
  offset_t                   word;
  logic                      idle;
  logic                      capture;
  logic                      tag_wr;
  logic [words_per_line-1:0] line_wr;
  offset_t                   beat;
  logic                      refill_done;
  logic                      hit_done;
  logic                      valid_hit;
  logic                      line_valid;
  line_u                     store_line;
  line_u                     fill_line;

  // Line base of the held fetch
  assign mem_addr = {held_addr.tag, held_addr.index, 4'h0};

  fetch_decode u_decode (
    .clk(clk), .rst(rst), .fetch(fetch), .capture(capture),
    .held_addr(held_addr), .index(index), .tag(tag), .word(word)
  );

  icache_ctrl u_ctrl (
    .clk(clk), .rst(rst), .fetch(fetch), .mem(mem),
    .valid_hit(valid_hit), .line_valid(line_valid),
    .idle(idle), .capture(capture), .tag_wr(tag_wr), .line_wr(line_wr),
    .beat(beat), .refill_done(refill_done), .hit_done(hit_done),
    .core_wait(core_wait), .mem_req(mem_req)
  );

  tag_store u_tags (
    .clk(clk), .rst(rst), .index(index), .tag(tag), .rd(idle), .wr(tag_wr),
    .hit(valid_hit), .line_valid(line_valid)
  );

  line_store u_lines (
    .clk(clk), .index(index), .rd(idle), .wr(line_wr),
    .wdata(fill_line), .rdata(store_line)
  );

  fetch_result u_result (
    .clk(clk), .rst(rst), .mem(mem), .beat(beat), .refill_done(refill_done),
    .hit_done(hit_done), .idle(idle), .fetch(fetch), .word(word),
    .store_line(store_line), .fill_line(fill_line), .core_data(core_data),
    .stats(stats)
  );

endmodule

// ==== tb_icache_mem.sv ====
// ====================
// Refill memory model
// ====================

`timescale 1ns/10ps

module tb_icache_mem
  import cache_geom_pkg::*;
  import fetch_bus_pkg::*;
#(
  parameter int unsigned seed_init = 32'h6983_3c52
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     mem_req,
  input  word_t    mem_addr,
  output mem_rsp_t mem,
  output int       lines_served
);

  integer seed;
  int     beat;
  int     wait_left;
  logic   armed;
  logic   pending;

  // Memory contents follow the byte address
  function automatic word_t word_at(input word_t addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  initial begin
    seed         = seed_init;
    beat         = 0;
    wait_left    = 0;
    armed        = 1'b0;
    pending      = 1'b0;
    lines_served = 0;
    mem.data     = '0;
    mem.stall    = 1'b1;
    forever begin
      @(negedge clk);
      if (rst) begin
        beat         = 0;
        armed        = 1'b0;
        pending      = 1'b0;
        lines_served = 0;
        mem.stall    = 1'b1;
      end else begin
        // Word offered last cycle was taken at the rising edge
        if (pending) begin
          pending = 1'b0;
          beat++;
          if (beat == words_per_line) lines_served++;
        end
        if (!mem_req) begin
          beat      = 0;
          armed     = 1'b0;
          mem.stall = 1'b1;
        end else begin
          // Pick 0 to 3 wait cycles for each beat
          if (!armed) begin
            wait_left = $unsigned($random(seed)) % 4;
            armed     = 1'b1;
          end
          if (wait_left != 0) begin
            wait_left--;
            mem.stall = 1'b1;
          end else begin
            mem.data  = word_at(mem_addr + 32'(beat * 4));
            mem.stall = 1'b0;
            armed     = 1'b0;
            pending   = 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== tb_icache.sv ====
// ====================
// Instruction cache testbench
// ====================

`timescale 1ns/10ps

module tb_icache
  import cache_geom_pkg::*;
  import fetch_bus_pkg::*;
();

  logic         clk;
  logic         rst;
  fetch_req_t   fetch;
  word_t        core_data;
  logic         core_wait;
  logic         mem_req;
  word_t        mem_addr;
  mem_rsp_t     mem;
  cache_stats_t stats;
  int           lines_served;

  integer       seed;
  int           errors;
  int           checks;
  int           tests;
  int           test_errors;
  string        test_name;

  // Direct-mapped presence model and expected counters
  logic         model_valid [num_lines];
  tag_t         model_tag [num_lines];
  cache_stats_t exp_stats;

  // Snapshot of one completed fetch for the compare process
  fetch_addr_t  chk_addr;
  word_t        chk_data;
  cache_stats_t chk_stats;
  cache_stats_t chk_exp;
  logic         chk_miss;
  logic         chk_saw_req;
  word_t        chk_mem_addr;
  int           chk_served;
  event         result_ready;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  icache_top dut (
    .clk(clk), .rst(rst), .fetch(fetch), .core_data(core_data), .core_wait(core_wait),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem(mem), .stats(stats)
  );

  tb_icache_mem #(.seed_init(32'h6983_3c52)) mem_model (
    .clk(clk), .rst(rst), .mem_req(mem_req), .mem_addr(mem_addr), .mem(mem),
    .lines_served(lines_served)
  );

  // Expected instruction word for a fetch address
  function automatic word_t expected_word(input fetch_addr_t addr);
    word_t aligned;
    aligned = {addr.tag, addr.index, addr.word, 2'b00};
    return aligned ^ 32'hA5A5_0000;
  endfunction

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // ====================
  // Compare process
  // ====================

  always @(result_ready) begin
    compare("core_data", expected_word(chk_addr), chk_data);
    compare("mem_req seen", chk_miss, chk_saw_req);
    if (chk_miss) compare("mem_addr", chk_addr & 32'hFFFF_FFF0, chk_mem_addr);
    compare("fetches", chk_exp.fetches, chk_stats.fetches);
    compare("hits", chk_exp.hits, chk_stats.hits);
    compare("misses", chk_exp.misses, chk_stats.misses);
    compare("lines served", chk_exp.misses, chk_served);
  end

  // One fetch that leaves req high for a back-to-back follower
  task automatic run_fetch(input fetch_addr_t addr);
    int    cycles;
    logic  miss;
    logic  saw_req;
    word_t seen_addr;
    miss = !(model_valid[addr.index] && model_tag[addr.index] == addr.tag);
    model_valid[addr.index] = 1'b1;
    model_tag[addr.index]   = addr.tag;
    exp_stats.fetches = exp_stats.fetches + 1;
    if (miss) exp_stats.misses = exp_stats.misses + 1;
    else exp_stats.hits = exp_stats.hits + 1;
    fetch.req  = 1'b1;
    fetch.addr = addr;
    cycles     = 0;
    saw_req    = 1'b0;
    seen_addr  = '0;
    @(negedge clk);
    while (core_wait && cycles < 200) begin
      if (mem_req && !saw_req) begin
        saw_req   = 1'b1;
        seen_addr = mem_addr;
      end
      @(negedge clk);
      cycles++;
    end
    if (core_wait) begin
      $display("Timeout: fetch of %h in test %s never completed", addr, test_name);
      $display("Done: errors found");
      $finish;
    end else begin
      chk_addr     = addr;
      chk_data     = core_data;
      chk_stats    = stats;
      chk_exp      = exp_stats;
      chk_miss     = miss;
      chk_saw_req  = saw_req;
      chk_mem_addr = seen_addr;
      chk_served   = lines_served;
      -> result_ready;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
    tests++;
  endtask

  task automatic end_test();
    fetch.req = 1'b0;
    @(negedge clk);
    $display("Test %s finished with %0d errors", test_name, errors - test_errors);
  endtask

  // ====================
  // Stimulus
  // ====================

  initial begin
    fetch_addr_t a;
    fetch_addr_t b;
    seed      = 32'h6983_3c52;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    test_name = "reset";
    exp_stats = '0;
    fetch     = '0;
    rst       = 1'b1;
    for (int i = 0; i < num_lines; i++) model_valid[i] = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    start_test("cold_line");
    a = 32'h0000_1240;
    for (int w = 0; w < words_per_line; w++) begin
      a.word = w;
      run_fetch(a);
    end
    end_test();

    // Same line again, back to back
    start_test("hit_repeat");
    for (int n = 0; n < 4; n++) begin
      a.word = 3 - n;
      run_fetch(a);
    end
    end_test();

    start_test("conflict");
    b     = a;
    b.tag = a.tag + 1;
    for (int n = 0; n < 3; n++) begin
      run_fetch(a);
      run_fetch(b);
    end
    end_test();

    // Small address range so lines both hit and get evicted
    start_test("random_mix");
    for (int n = 0; n < 40; n++) begin
      a.tag      = 22'h10 + ($unsigned($random(seed)) % 2);
      a.index    = $unsigned($random(seed)) % 8;
      a.word     = $unsigned($random(seed)) % 4;
      a.byte_sel = 2'b00;
      if ($random(seed) & 1) begin
        fetch.req = 1'b0;
        @(negedge clk);
      end
      run_fetch(a);
    end
    end_test();

    start_test("reset_clear");
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    compare("fetches", 0, stats.fetches);
    compare("hits", 0, stats.hits);
    compare("misses", 0, stats.misses);
    for (int i = 0; i < num_lines; i++) model_valid[i] = 1'b0;
    exp_stats = '0;
    a = 32'h0000_1240;
    run_fetch(a);
    end_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
cache_geom_pkg.sv
fetch_bus_pkg.sv
tag_store.sv
line_store.sv
fetch_decode.sv
icache_ctrl.sv
fetch_result.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  # Packages first
  - cache_geom_pkg.sv
  - fetch_bus_pkg.sv
  # Cache blocks and top level
  - tag_store.sv
  - line_store.sv
  - fetch_decode.sv
  - icache_ctrl.sv
  - fetch_result.sv
  - icache_top.sv
  # Testbench
  - target: test
    files:
      - tb_icache_mem.sv
      - tb_icache.sv
